// ==== filelist.f ====
design/usbPePkg.sv
design/epTransFifo.sv
design/deviceStateTracker.sv
design/rxPacketSink.sv
design/txPacketSource.sv
design/usbPe.sv
tb/usbPe_sva.sv
tb/usbPeTb.sv

// ==== tb/usbPeTb.sv ====
`timescale 1ns/1ps

module usbPeTb;
    import usbPePkg::*;

    logic clk48 = 1'b0;
    logic reset;
    logic usbResetDetected;
    logic setAddress;
    DevAddr newAddress;
    logic setConfig;
    EpIndex epSelect;
    UsbByte rxData;
    logic rxDataValid;
    logic rxIsLastByte;
    logic keepPacket;
    logic txStart;
    logic txHandshakeDone;
    logic txHandshakeOk;
    logic txAcceptNewData;
    EpPopCtrl  [endpointCount-1:0] epInPop;
    EpFillCtrl [endpointCount-1:0] epOutFill;
    UsbByte    [endpointCount-1:0] epOutData;

    logic ackUsbResetDetect;
    DeviceState deviceState;
    DevAddr deviceAddr;
    logic rxAcceptNewData;
    logic rxDone;
    logic rxOk;
    logic txReqSendPacket;
    logic txDataValid;
    logic txIsLastByte;
    UsbByte txData;
    logic txBusy;
    logic   [endpointCount-1:0] epInDataAvailable;
    UsbByte [endpointCount-1:0] epInData;
    logic   [endpointCount-1:0] epOutFull;

    UsbByte inModel [endpointCount][$];     // Committed bytes per IN FIFO
    UsbByte outModel [endpointCount][$];    // Queued bytes per OUT FIFO
    logic [31:0] rngState = 32'he6a91516;
    int checkCount = 0;
    int errorCount = 0;
    int timeoutCount = 0;

    always #20 clk48 = ~clk48;              // 40 ns period

    usbPe usbPe_inst (.*);

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        timeoutCount++;
        $display("Timed out at %0t ns waiting for %s", $time, what);
    endtask

    task automatic nextCycle();
        @(posedge clk48);
        @(negedge clk48);
    endtask

    // Holds one receive byte until the DUT takes it
    task automatic offerRxByte(input UsbByte b, input logic last, input logic keep);
        int guard;
        logic taken;
        rxData = b;
        rxDataValid = 1'b1;
        rxIsLastByte = last;
        keepPacket = keep;
        taken = 1'b0;
        guard = 0;
        while (!taken && guard < 16) begin
            @(posedge clk48);
            taken = rxAcceptNewData;
            @(negedge clk48);
            guard++;
        end
        rxDataValid = 1'b0;
        rxIsLastByte = 1'b0;
        if (!taken) reportTimeout("rxAcceptNewData");
    endtask

    task automatic drainInEndpoint(input int ep);
        UsbByte expected;
        while (inModel[ep].size() > 0) begin
            expected = inModel[ep].pop_front();
            epInPop[ep].popData = 1'b1;
            @(posedge clk48);
            checkValue("epInDataAvailable", epInDataAvailable[ep], 1);
            checkValue("epInData", epInData[ep], expected);
            @(negedge clk48);
        end
        epInPop[ep] = '0;
        epInPop[ep].transDone = 1'b1;       // Retire what was read
        epInPop[ep].transSuccess = 1'b1;
        nextCycle();
        epInPop[ep] = '0;
        @(posedge clk48);
        checkValue("epInDataAvailable", epInDataAvailable, 0);
        @(negedge clk48);
    endtask

    task automatic receivePacket(input int ep, input int len, input logic keep,
                                 input logic expectOk);
        UsbByte payload[$];
        UsbByte b;
        int guard;
        logic seenDone;
        epSelect = EpIndex'(ep);
        for (int i = 0; i < len; i++) begin
            b = UsbByte'(nextRandom());
            payload.push_back(b);
            offerRxByte(b, i == len - 1, (i == len - 1) ? keep : 1'b1);
        end
        seenDone = 1'b0;
        guard = 0;
        while (!seenDone && guard < 8) begin
            @(posedge clk48);
            if (rxDone) begin
                seenDone = 1'b1;
                checkValue("rxOk", rxOk, expectOk);
                checkValue("rxAcceptNewData", rxAcceptNewData, 0);  // Closing cycle
            end
            @(negedge clk48);
            guard++;
        end
        if (!seenDone) reportTimeout("rxDone");
        if (expectOk) begin
            foreach (payload[i]) inModel[ep].push_back(payload[i]);
            seenDone = 1'b0;
            guard = 0;
            while (!seenDone && guard < 2) begin
                @(posedge clk48);
                seenDone = epInDataAvailable[ep];
                if (seenDone) checkValue("epInDataAvailable", epInDataAvailable, 32'(1 << ep));
                @(negedge clk48);
                guard++;
            end
            if (!seenDone) reportTimeout("epInDataAvailable");
            drainInEndpoint(ep);
        end else begin
            repeat (3) begin                // Rolled back, nothing shows
                @(posedge clk48);
                checkValue("epInDataAvailable", epInDataAvailable, 0);
                @(negedge clk48);
            end
        end
    endtask

    task automatic fillOutEndpoint(input int ep, input int len);
        UsbByte b;
        for (int i = 0; i < len; i++) begin
            b = UsbByte'(nextRandom());
            outModel[ep].push_back(b);
            epOutFill[ep].dataValid = 1'b1;
            epOutData[ep] = b;
            nextCycle();
        end
        epOutFill[ep] = '0;
        epOutFill[ep].transDone = 1'b1;     // Commit the packet
        epOutFill[ep].transSuccess = 1'b1;
        nextCycle();
        epOutFill[ep] = '0;
        @(posedge clk48);
        checkValue("epOutFull", epOutFull[ep], outModel[ep].size() == 15);  // One slot kept free
        @(negedge clk48);
    endtask

    task automatic pulseTxStart(input int ep);
        epSelect = EpIndex'(ep);
        txAcceptNewData = 1'b0;
        txStart = 1'b1;
        nextCycle();
        txStart = 1'b0;
    endtask

    // Streams the queued OUT packet under random back-pressure
    task automatic streamOutPacket(input int ep);
        int idx;
        int guard;
        int len;
        logic seenReq;
        len = outModel[ep].size();
        pulseTxStart(ep);
        seenReq = 1'b0;
        guard = 0;
        while (!seenReq && guard < 4) begin
            @(posedge clk48);
            seenReq = txReqSendPacket;
            @(negedge clk48);
            guard++;
        end
        if (!seenReq) reportTimeout("txReqSendPacket");
        idx = 0;
        guard = 0;
        while (idx < len && guard < 200) begin
            txAcceptNewData = (nextRandom() % 4) != 0;
            @(posedge clk48);
            if (txDataValid) begin
                checkValue("txReqSendPacket", txReqSendPacket, 1);
                checkValue("txData", txData, outModel[ep][idx]);   // Also under stall
                checkValue("txIsLastByte", txIsLastByte, idx == len - 1);
                if (txAcceptNewData) idx++;
            end
            @(negedge clk48);
            guard++;
        end
        txAcceptNewData = 1'b0;
        if (idx < len) reportTimeout("transmit bytes");
        @(posedge clk48);
        checkValue("txReqSendPacket", txReqSendPacket, 0);
        checkValue("txDataValid", txDataValid, 0);
        checkValue("txBusy", txBusy, 1);
        checkValue("epOutFull", epOutFull[ep], len == 15);     // Sent bytes not yet retired
        @(negedge clk48);
    endtask

    task automatic finishHandshake(input int ep, input logic ok);
        int guard;
        logic idleSeen;
        txHandshakeOk = ok;
        txHandshakeDone = 1'b1;
        nextCycle();
        txHandshakeDone = 1'b0;
        idleSeen = 1'b0;
        guard = 0;
        while (!idleSeen && guard < 4) begin
            @(posedge clk48);
            idleSeen = !txBusy;
            @(negedge clk48);
            guard++;
        end
        if (!idleSeen) reportTimeout("txBusy low");
        if (ok) outModel[ep].delete();
    endtask

    task automatic checkNothingToSend(input int ep);
        pulseTxStart(ep);
        repeat (4) begin
            @(posedge clk48);
            checkValue("txReqSendPacket", txReqSendPacket, 0);
            checkValue("txBusy", txBusy, 0);
            checkValue("epOutFull", epOutFull[ep], 0);
            @(negedge clk48);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        DevAddr addr;
        reset = 1'b1;
        usbResetDetected = 1'b0;
        setAddress = 1'b0;
        newAddress = '0;
        setConfig = 1'b0;
        epSelect = '0;
        rxData = '0;
        rxDataValid = 1'b0;
        rxIsLastByte = 1'b0;
        keepPacket = 1'b0;
        txStart = 1'b0;
        txHandshakeDone = 1'b0;
        txHandshakeOk = 1'b0;
        txAcceptNewData = 1'b0;
        epInPop = '0;
        epOutFill = '0;
        epOutData = '0;
        repeat (8) @(posedge clk48);
        @(negedge clk48);
        reset = 1'b0;

        // Quiet outputs out of reset
        @(posedge clk48);
        checkValue("deviceState", deviceState, devNotReset);
        checkValue("rxAcceptNewData", rxAcceptNewData, 0);
        checkValue("txReqSendPacket", txReqSendPacket, 0);
        checkValue("txDataValid", txDataValid, 0);
        checkValue("rxDone", rxDone, 0);
        checkValue("ackUsbResetDetect", ackUsbResetDetect, 0);
        checkValue("epInDataAvailable", epInDataAvailable, 0);
        @(negedge clk48);

        rxData = 8'h5a;                     // Refused before a bus reset
        rxDataValid = 1'b1;
        rxIsLastByte = 1'b1;
        repeat (4) begin
            @(posedge clk48);
            checkValue("rxAcceptNewData", rxAcceptNewData, 0);
            checkValue("rxDone", rxDone, 0);
            @(negedge clk48);
        end
        rxDataValid = 1'b0;
        rxIsLastByte = 1'b0;
        fillOutEndpoint(0, 1 + nextRandom() % 15);
        pulseTxStart(0);                    // Ignored, stays queued
        repeat (4) begin
            @(posedge clk48);
            checkValue("txReqSendPacket", txReqSendPacket, 0);
            checkValue("epInDataAvailable", epInDataAvailable, 0);
            @(negedge clk48);
        end

        // ==================================================
        // Device states
        // ==================================================
        usbResetDetected = 1'b1;
        nextCycle();
        usbResetDetected = 1'b0;
        @(posedge clk48);
        checkValue("deviceState", deviceState, devReset);
        checkValue("ackUsbResetDetect", ackUsbResetDetect, 1);
        @(negedge clk48);
        addr = DevAddr'(nextRandom()) | 7'h01;
        newAddress = addr;
        setAddress = 1'b1;
        nextCycle();
        setAddress = 1'b0;
        @(posedge clk48);
        checkValue("deviceState", deviceState, devAddrAssigned);
        checkValue("deviceAddr", deviceAddr, addr);
        checkValue("ackUsbResetDetect", ackUsbResetDetect, 0);
        @(negedge clk48);
        setConfig = 1'b1;
        nextCycle();
        setConfig = 1'b0;
        @(posedge clk48);
        checkValue("deviceState", deviceState, devConfigured);
        checkValue("deviceAddr", deviceAddr, addr);
        @(negedge clk48);
        usbResetDetected = 1'b1;            // Later bus reset
        nextCycle();
        usbResetDetected = 1'b0;
        @(posedge clk48);
        checkValue("deviceState", deviceState, devReset);
        checkValue("deviceAddr", deviceAddr, 0);
        @(negedge clk48);

        // ==================================================
        // Receive packets
        // ==================================================
        repeat (6) begin
            receivePacket(nextRandom() % endpointCount, 1 + nextRandom() % 15, 1'b1, 1'b1);
        end
        receivePacket(nextRandom() % endpointCount, 15, 1'b1, 1'b1);    // Full depth
        receivePacket(nextRandom() % endpointCount, 1 + nextRandom() % 15, 1'b0, 1'b0);
        receivePacket(nextRandom() % endpointCount, 16 + nextRandom() % 5, 1'b1, 1'b0);
        receivePacket(nextRandom() % endpointCount, 1 + nextRandom() % 15, 1'b1, 1'b1);

        // ==================================================
        // Transmit packets
        // ==================================================
        streamOutPacket(0);                 // Packet queued before bus reset
        finishHandshake(0, 1'b0);
        streamOutPacket(0);                 // Retry sends the same bytes
        finishHandshake(0, 1'b1);
        checkNothingToSend(0);
        for (int ep = 1; ep < endpointCount; ep++) begin
            fillOutEndpoint(ep, 15);        // Full depth
            streamOutPacket(ep);
            finishHandshake(ep, 1'b1);
            checkNothingToSend(ep);
        end

        $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checkCount, errorCount, timeoutCount, usbPe_inst.usbPeSvaInst.failCount);
        if (errorCount == 0 && timeoutCount == 0 && usbPe_inst.usbPeSvaInst.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb/usbPe_sva.sv ====
`timescale 1ns/1ps

module usbPeSva (
    input logic                 clk48,
    input logic                 reset,
    input logic                 txDataValid,
    input logic                 txReqSendPacket,
    input logic                 ackUsbResetDetect,
    input logic                 rxAcceptNewData,
    input usbPePkg::DeviceState deviceState
);
    import usbPePkg::*;

    int unsigned failCount = 0;     // Read by the testbench at the end

    // ==================================================
    // Transmit interface
    // ==================================================
    txValidInsideRequest: assert property (
        @(posedge clk48) disable iff (reset)
        txDataValid |-> txReqSendPacket
    ) else begin
        $error("txDataValid high outside a send request");
        failCount++;
    end

    // ==================================================
    // Device state
    // ==================================================
    resetAckMatchesState: assert property (
        @(posedge clk48) disable iff (reset)
        ackUsbResetDetect == (deviceState == devReset)
    ) else begin
        $error("ackUsbResetDetect disagrees with the device state");
        failCount++;
    end

    // Inactive device neither takes nor sends bytes
    quietBeforeBusReset: assert property (
        @(posedge clk48) disable iff (reset)
        (deviceState == devNotReset) |-> (!rxAcceptNewData && !txReqSendPacket)
    ) else begin
        $error("Traffic while the device has seen no bus reset");
        failCount++;
    end

endmodule

bind usbPe usbPeSva usbPeSvaInst (
    .clk48             (clk48),
    .reset             (reset),
    .txDataValid       (txDataValid),
    .txReqSendPacket   (txReqSendPacket),
    .ackUsbResetDetect (ackUsbResetDetect),
    .rxAcceptNewData   (rxAcceptNewData),
    .deviceState       (deviceState)
);

// ==== design/usbPe.sv ====
`timescale 1ns/1ps

module usbPe (
    input  logic                 clk48,
    input  logic                 reset,
    // Device control
    input  logic                 usbResetDetected,
    input  logic                 setAddress,
    input  usbPePkg::DevAddr     newAddress,
    input  logic                 setConfig,
    input  usbPePkg::EpIndex     epSelect,
    // Receive stream
    input  usbPePkg::UsbByte     rxData,
    input  logic                 rxDataValid,
    input  logic                 rxIsLastByte,
    input  logic                 keepPacket,
    // Transmit control
    input  logic                 txStart,
    input  logic                 txHandshakeDone,
    input  logic                 txHandshakeOk,
    input  logic                 txAcceptNewData,
    // Host side endpoint ports
    input  usbPePkg::EpPopCtrl   [usbPePkg::endpointCount-1:0] epInPop,
    input  usbPePkg::EpFillCtrl  [usbPePkg::endpointCount-1:0] epOutFill,
    input  usbPePkg::UsbByte     [usbPePkg::endpointCount-1:0] epOutData,
    // Outputs
    output logic                 ackUsbResetDetect,
    output usbPePkg::DeviceState deviceState,
    output usbPePkg::DevAddr     deviceAddr,
    output logic                 rxAcceptNewData,
    output logic                 rxDone,
    output logic                 rxOk,
    output logic                 txReqSendPacket,
    output logic                 txDataValid,
    output logic                 txIsLastByte,
    output usbPePkg::UsbByte     txData,
    output logic                 txBusy,
    output logic                 [usbPePkg::endpointCount-1:0] epInDataAvailable,
    output usbPePkg::UsbByte     [usbPePkg::endpointCount-1:0] epInData,
    output logic                 [usbPePkg::endpointCount-1:0] epOutFull
);
    import usbPePkg::*;

    logic      deviceActive;
    EpFillCtrl rxFill;          // Engine side, before endpoint steering
    UsbByte    rxFillData;
    EpPopCtrl  txPop;

    logic   [endpointCount-1:0] inFull;
    logic   [endpointCount-1:0] outAvail;
    logic   [endpointCount-1:0] outLast;
    UsbByte [endpointCount-1:0] outData;

    deviceStateTracker stateTracker (
        .clk48             (clk48),
        .reset             (reset),
        .usbResetDetected  (usbResetDetected),
        .setAddress        (setAddress),
        .newAddress        (newAddress),
        .setConfig         (setConfig),
        .deviceState       (deviceState),
        .deviceAddr        (deviceAddr),
        .ackUsbResetDetect (ackUsbResetDetect),
        .deviceActive      (deviceActive)
    );

    // ==================================================
    // Engines, fed from the selected endpoint
    // ==================================================
    rxPacketSink rxSink (
        .clk48           (clk48),
        .reset           (reset),
        .deviceActive    (deviceActive),
        .rxData          (rxData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .keepPacket      (keepPacket),
        .fifoFull        (inFull[epSelect]),
        .rxAcceptNewData (rxAcceptNewData),
        .fill            (rxFill),
        .fillData        (rxFillData),
        .rxDone          (rxDone),
        .rxOk            (rxOk)
    );

    txPacketSource txSource (
        .clk48           (clk48),
        .reset           (reset),
        .deviceActive    (deviceActive),
        .txStart         (txStart),
        .txHandshakeDone (txHandshakeDone),
        .txHandshakeOk   (txHandshakeOk),
        .txAcceptNewData (txAcceptNewData),
        .fifoAvailable   (outAvail[epSelect]),
        .fifoLast        (outLast[epSelect]),
        .fifoData        (outData[epSelect]),
        .pop             (txPop),
        .txReqSendPacket (txReqSendPacket),
        .txDataValid     (txDataValid),
        .txIsLastByte    (txIsLastByte),
        .txData          (txData),
        .txBusy          (txBusy)
    );

    // ==================================================
    // Endpoint FIFO pairs
    // ==================================================
    for (genvar ep = 0; ep < endpointCount; ep++) begin : gEndpoint
        EpFillCtrl inFill;
        EpPopCtrl  outPop;

        // Only the selected endpoint sees engine control
        assign inFill = (epSelect == EpIndex'(ep)) ? rxFill : '0;
        assign outPop = (epSelect == EpIndex'(ep)) ? txPop : '0;

        epTransFifo inFifo (            // Host reads received packets
            .clk48         (clk48),
            .reset         (reset),
            .fill          (inFill),
            .dataIn        (rxFillData),
            .pop           (epInPop[ep]),
            .full          (inFull[ep]),
            .dataAvailable (epInDataAvailable[ep]),
            .lastAvailable (),          // Host pops by availability
            .dataOut       (epInData[ep])
        );

        epTransFifo outFifo (           // Host queues packets to send
            .clk48         (clk48),
            .reset         (reset),
            .fill          (epOutFill[ep]),
            .dataIn        (epOutData[ep]),
            .pop           (outPop),
            .full          (epOutFull[ep]),
            .dataAvailable (outAvail[ep]),
            .lastAvailable (outLast[ep]),
            .dataOut       (outData[ep])
        );
    end

endmodule

// ==== design/txPacketSource.sv ====
`timescale 1ns/1ps

module txPacketSource (
    input  logic               clk48,
    input  logic               reset,
    input  logic               deviceActive,
    input  logic               txStart,
    input  logic               txHandshakeDone,
    input  logic               txHandshakeOk,
    input  logic               txAcceptNewData,
    input  logic               fifoAvailable,
    input  logic               fifoLast,
    input  usbPePkg::UsbByte   fifoData,
    output usbPePkg::EpPopCtrl pop,
    output logic               txReqSendPacket,
    output logic               txDataValid,
    output logic               txIsLastByte,
    output usbPePkg::UsbByte   txData,
    output logic               txBusy
);
    import usbPePkg::*;

    typedef enum logic [1:0] {
        idle,
        send,               // Streaming bytes
        awaitHandshake      // Packet out, waiting for ACK or not
    } TxState;

    TxState state;
    logic   txHandshake;
    logic   popDone;        // Registered handshake outcome
    logic   popOk;

    // ==================================================
    // Transmit stream
    // ==================================================
    assign txReqSendPacket = state == send;
    assign txDataValid = (state == send) && fifoAvailable;
    assign txIsLastByte = (state == send) && fifoLast;
    assign txData = fifoData;                           // Held while stalled
    assign txHandshake = txDataValid && txAcceptNewData;

    // Busy up to the cycle that applies the commit or rewind
    assign txBusy = (state != idle) || popDone;

    always_ff @(posedge clk48) begin
        if (reset) begin
            state <= idle;
            popDone <= 1'b0;
            popOk <= 1'b0;
        end else begin
            popDone <= 1'b0;
            unique case (state)
                idle: begin
                    // Empty FIFO sends nothing
                    if (txStart && deviceActive && fifoAvailable && !popDone) begin
                        state <= send;
                    end
                end
                send: begin
                    if (txHandshake && fifoLast) begin
                        state <= awaitHandshake;
                    end
                end
                awaitHandshake: begin
                    if (txHandshakeDone) begin
                        state <= idle;
                        popDone <= 1'b1;
                        popOk <= txHandshakeOk;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ==================================================
    // FIFO pop control
    // ==================================================
    always_comb begin
        pop.popData = txHandshake;      // Tentative read advance
        pop.transDone = popDone;
        pop.transSuccess = popOk;       // Retire on ACK, else rewind
    end

endmodule

// ==== design/rxPacketSink.sv ====
`timescale 1ns/1ps

module rxPacketSink (
    input  logic                clk48,
    input  logic                reset,
    input  logic                deviceActive,
    input  usbPePkg::UsbByte    rxData,
    input  logic                rxDataValid,
    input  logic                rxIsLastByte,
    input  logic                keepPacket,
    input  logic                fifoFull,
    output logic                rxAcceptNewData,
    output usbPePkg::EpFillCtrl fill,
    output usbPePkg::UsbByte    fillData,
    output logic                rxDone,
    output logic                rxOk
);
    import usbPePkg::*;

    logic rxHandshake;
    logic overflow;         // Some byte of this packet was lost
    logic lastByteOk;

    // ==================================================
    // Byte acceptance
    // ==================================================
    // Bytes keep flowing on a full FIFO so the packet drains
    // Closing cycle refuses the next packet
    assign rxAcceptNewData = deviceActive && !rxDone;
    assign rxHandshake = rxDataValid && rxAcceptNewData;

    assign fillData = rxData;

    // Packet kept only if whole and wanted
    assign lastByteOk = keepPacket && !overflow && !fifoFull;

    always_ff @(posedge clk48) begin
        if (reset) begin
            overflow <= 1'b0;
            rxDone <= 1'b0;
            rxOk <= 1'b0;
        end else begin
            rxDone <= rxHandshake && rxIsLastByte;  // One cycle pulse
            if (rxHandshake && rxIsLastByte) begin
                rxOk <= lastByteOk;
            end
            if (rxDone) begin
                overflow <= 1'b0;                   // Fresh packet next
            end else if (rxHandshake && fifoFull) begin
                overflow <= 1'b1;
            end
        end
    end

    // ==================================================
    // FIFO fill control
    // ==================================================
    always_comb begin
        fill.dataValid = rxHandshake;   // FIFO drops it when full
        fill.transDone = rxDone;        // Commit or roll back on this edge
        fill.transSuccess = rxOk;
    end

endmodule

// ==== design/deviceStateTracker.sv ====
`timescale 1ns/1ps

module deviceStateTracker (
    input  logic                 clk48,
    input  logic                 reset,
    input  logic                 usbResetDetected,
    input  logic                 setAddress,
    input  usbPePkg::DevAddr     newAddress,
    input  logic                 setConfig,
    output usbPePkg::DeviceState deviceState,
    output usbPePkg::DevAddr     deviceAddr,
    output logic                 ackUsbResetDetect,
    output logic                 deviceActive
);
    import usbPePkg::*;

    // ==================================================
    // Device state graph
    // ==================================================
    always_ff @(posedge clk48) begin
        if (reset) begin
            deviceState <= devNotReset;
            deviceAddr <= '0;
        end else if (usbResetDetected) begin
            // Bus reset wins from any state
            deviceState <= devReset;
            deviceAddr <= '0;               // Back to the default address
        end else begin
            unique case (deviceState)
                devNotReset: begin
                    // Waits for the first bus reset
                end
                devReset: begin
                    if (setAddress) begin
                        deviceState <= devAddrAssigned;
                        deviceAddr <= newAddress;
                    end
                end
                devAddrAssigned: begin
                    if (setConfig) begin
                        deviceState <= devConfigured;
                    end
                end
                devConfigured: begin
                    // Only a bus reset leaves
                end
                default: begin
                    deviceState <= devNotReset;
                end
            endcase
        end
    end

    assign ackUsbResetDetect = deviceState == devReset;     // Acks while in reset
    assign deviceActive = deviceState != devNotReset;       // Engines enabled

endmodule

// ==== design/epTransFifo.sv ====
`timescale 1ns/1ps

module epTransFifo (
    input  logic                clk48,
    input  logic                reset,
    input  usbPePkg::EpFillCtrl fill,
    input  usbPePkg::UsbByte    dataIn,
    input  usbPePkg::EpPopCtrl  pop,
    output logic                full,
    output logic                dataAvailable,
    output logic                lastAvailable,
    output usbPePkg::UsbByte    dataOut
);
    import usbPePkg::*;

    localparam int depth = 2 ** epAddrWidth;

    typedef logic [epAddrWidth-1:0] FifoPtr;

    // ==================================================
    // Storage and pointers
    // ==================================================
    UsbByte mem [depth];            // One slot always kept free

    FifoPtr wrCommit;               // End of committed data
    FifoPtr wrTent;                 // Write position of the open packet
    FifoPtr rdCommit;               // Start of unretired data
    FifoPtr rdTent;                 // Read position of the open packet
    FifoPtr wrTentNext;
    FifoPtr rdTentNext;
    logic   doWrite;
    logic   doRead;

    // Full against the committed read side
    // Bytes popped but not retired may still be rewound
    assign full = FifoPtr'(wrTent + 1'b1) == rdCommit;

    // Reader only sees committed bytes
    assign dataAvailable = rdTent != wrCommit;
    assign lastAvailable = FifoPtr'(rdTent + 1'b1) == wrCommit;  // Exactly one left

    assign dataOut = mem[rdTent];   // Fall-through read

    assign doWrite = fill.dataValid && !full;       // Full write dropped
    assign doRead = pop.popData && dataAvailable;   // Pop on empty ignored

    assign wrTentNext = doWrite ? FifoPtr'(wrTent + 1'b1) : wrTent;
    assign rdTentNext = doRead ? FifoPtr'(rdTent + 1'b1) : rdTent;

    always_ff @(posedge clk48) begin
        if (doWrite) begin
            mem[wrTent] <= dataIn;
        end
    end

    // ==================================================
    // Fill side transaction
    // ==================================================
    always_ff @(posedge clk48) begin
        if (reset) begin
            wrCommit <= '0;
            wrTent <= '0;
        end else if (fill.transDone) begin
            if (fill.transSuccess) begin
                wrCommit <= wrTentNext;     // Packet kept, incl. a byte on this edge
                wrTent <= wrTentNext;
            end else begin
                wrTent <= wrCommit;         // Packet dropped
            end
        end else begin
            wrTent <= wrTentNext;
        end
    end

    // ==================================================
    // Pop side transaction
    // ==================================================
    always_ff @(posedge clk48) begin
        if (reset) begin
            rdCommit <= '0;
            rdTent <= '0;
        end else if (pop.transDone) begin
            if (pop.transSuccess) begin
                rdCommit <= rdTentNext;     // Host acked, space freed
                rdTent <= rdTentNext;
            end else begin
                rdTent <= rdCommit;         // Rewind for a retry
            end
        end else begin
            rdTent <= rdTentNext;
        end
    end

endmodule

// ==== design/usbPePkg.sv ====
package usbPePkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int endpointCount = 2;           // Endpoints with an IN/OUT FIFO pair
    localparam int epAddrWidth = 4;             // FIFO pointer width, 15 usable bytes
    localparam int epIndexWidth = (endpointCount > 1) ? $clog2(endpointCount) : 1;

    // ==================================================
    // Data types
    // ==================================================
    typedef logic [7:0] UsbByte;                // One byte on the USB data paths
    typedef logic [6:0] DevAddr;                // Device address from SET_ADDRESS
    typedef logic [epIndexWidth-1:0] EpIndex;   // Endpoint number

    // Device states as seen by the host
    typedef enum logic [1:0] {
        devNotReset,        // Ignores everything but a bus reset
        devReset,           // Default address, answers enumeration
        devAddrAssigned,    // Own address stored
        devConfigured       // Configuration set, functions usable
    } DeviceState;

    // Fill side of a transactional FIFO
    typedef struct packed {
        logic dataValid;    // Write one byte
        logic transDone;    // End of packet
        logic transSuccess; // Keep the packet
    } EpFillCtrl;

    // Pop side of a transactional FIFO
    typedef struct packed {
        logic popData;      // Advance one byte
        logic transDone;    // End of packet
        logic transSuccess; // Retire the packet
    } EpPopCtrl;

endpackage
